/* cps_mmr.f */
cps_mmr_pkg.sv
cps_cfg_chain.sv
cps_a_regs.sv
cps_b_regs.sv
cps_mmr_top.sv
+incdir+.
cps_mmr_tb.sv

/* Makefile */
# Verilator lint and simulation of the CPS-A/CPS-B register block

VERILATOR ?= verilator
TOP       ?= cps_mmr_tb
FLIST     ?= cps_mmr.f
# random seed as a decimal number, default 0x0a011771
SEED      ?= 167843697
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) \
		-Gseed=$(SEED) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf $(OBJ_DIR)

/* cps_mmr_tb_table.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus table of the register block testbench, included in its module.
// CPS-B word addresses below are what the configuration chain loads.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPS_MMR_TB_TABLE_SVH
`define CPS_MMR_TB_TABLE_SVH

typedef enum logic [2:0] {OP_CFG, OP_AWR, OP_BWR, OP_BRD, OP_CLR, OP_INP, OP_IDLE} op_e;
typedef enum logic [3:0] {
    K_NONE, K_CFG, K_MMR, K_LAYER, K_PRIO0, K_PRIO1, K_PRIO2, K_PRIO3, K_PAL, K_DMA, K_COPY
} chk_e;
// where the expected value comes from
typedef enum logic [2:0] {X_TAB, X_RAND, X_RLO, X_RHI, X_IN2, X_IN3} exp_e;

typedef struct packed {
    op_e    op;
    waddr_t addr;
    dsn_t   dsn;
    word_t  data;
    logic   rnd;
    chk_e   chk;
    exp_e   src;
    word_t  exp;
} row_t;

localparam waddr_t B_ID    = 5'h12;
localparam waddr_t B_MULT1 = 5'h01;
localparam waddr_t B_MULT2 = 5'h02;
localparam waddr_t B_RSLT0 = 5'h03;
localparam waddr_t B_RSLT1 = 5'h04;
localparam waddr_t B_LAYER = 5'h05;
localparam waddr_t B_PRIO0 = 5'h06;
localparam waddr_t B_PRIO1 = 5'h07;
localparam waddr_t B_PRIO2 = 5'h08;
localparam waddr_t B_PRIO3 = ADDR_OFF;
localparam waddr_t B_IN2   = 5'h0a;
localparam waddr_t B_IN3   = 5'h0b;
localparam waddr_t B_PALP  = 5'h0c;

// chain contents by position with position 22 sent first
localparam byte_t CFG_LIST [CFG_BYTES] = '{
    {2'b00, B_ID, 1'b0}, 8'ha5, {2'b00, B_MULT1, 1'b0}, {2'b00, B_MULT2, 1'b0},
    {2'b00, B_RSLT0, 1'b0}, {2'b00, B_RSLT1, 1'b0}, {2'b00, B_LAYER, 1'b0},
    {2'b00, B_PRIO0, 1'b0}, {2'b00, B_PRIO1, 1'b0}, {2'b00, B_PRIO2, 1'b0},
    {2'b00, B_PRIO3, 1'b0}, {2'b00, B_IN2, 1'b0}, {2'b00, B_IN3, 1'b0},
    {2'b00, B_PALP, 1'b0}, 8'h11, 8'h22, 8'h33, 8'h44, 8'h2b, 8'h34, 8'h12, 8'hff, 8'h0f
};

localparam int ROWS = 35;

row_t table_rows [ROWS] = '{
    '{OP_CFG,  5'h00,        2'b11, 16'h0000, 1'b0, K_CFG,   X_TAB,  16'h0000},
    '{OP_AWR,  A_OBJ_BASE,   2'b00, 16'h0000, 1'b1, K_DMA,   X_TAB,  16'h0001},
    '{OP_CLR,  5'h00,        2'b11, 16'h0000, 1'b0, K_DMA,   X_TAB,  16'h0000},
    '{OP_AWR,  A_SCR1_BASE,  2'b00, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_SCR1_BASE,  2'b01, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_SCR1_BASE,  2'b10, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_SCR1_BASE,  2'b11, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_HPOS1,      2'b10, 16'h1234, 1'b0, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_PPU_CTRL,   2'b00, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_AWR,  A_PAL_BASE,   2'b00, 16'h0000, 1'b1, K_COPY,  X_TAB,  16'h0000},
    '{OP_AWR,  A_PAL_BASE,   2'b01, 16'h0000, 1'b1, K_COPY,  X_TAB,  16'h0000},
    '{OP_IDLE, 5'h00,        2'b11, 16'h0000, 1'b0, K_COPY,  X_TAB,  16'h0001},
    '{OP_IDLE, 5'h00,        2'b11, 16'h0000, 1'b0, K_COPY,  X_TAB,  16'h0000},
    '{OP_BWR,  B_LAYER,      2'b00, 16'h0000, 1'b1, K_LAYER, X_RAND, 16'h0000},
    '{OP_BRD,  B_LAYER,      2'b11, 16'h0000, 1'b0, K_MMR,   X_RAND, 16'h0000},
    '{OP_BWR,  B_LAYER,      2'b01, 16'h0000, 1'b0, K_LAYER, X_RAND, 16'h0000},
    '{OP_BWR,  B_LAYER,      2'b10, 16'h0000, 1'b0, K_LAYER, X_RAND, 16'h0000},
    '{OP_BWR,  B_PRIO0,      2'b00, 16'h0f0f, 1'b0, K_PRIO0, X_TAB,  16'h0f0f},
    '{OP_BWR,  B_PRIO1,      2'b00, 16'h5a3c, 1'b0, K_PRIO1, X_TAB,  16'h5a3c},
    '{OP_BWR,  B_PRIO2,      2'b00, 16'hcafe, 1'b0, K_PRIO2, X_TAB,  16'hcafe},
    '{OP_BWR,  B_PRIO3,      2'b00, 16'hbeef, 1'b0, K_PRIO3, X_TAB,  16'h0000},
    '{OP_BWR,  B_PALP,       2'b00, 16'h0015, 1'b0, K_PAL,   X_TAB,  16'h0015},
    '{OP_BRD,  B_PRIO0,      2'b11, 16'h0000, 1'b0, K_MMR,   X_TAB,  16'h0f0f},
    '{OP_BRD,  B_PALP,       2'b11, 16'h0000, 1'b0, K_MMR,   X_TAB,  16'h0015},
    '{OP_BRD,  B_ID,         2'b11, 16'h0000, 1'b0, K_MMR,   X_TAB,  16'h0a05},
    '{OP_BWR,  B_MULT1,      2'b00, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_BWR,  B_MULT2,      2'b00, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_IDLE, 5'h00,        2'b11, 16'h0000, 1'b0, K_NONE,  X_TAB,  16'h0000},
    '{OP_BRD,  B_RSLT0,      2'b11, 16'h0000, 1'b0, K_MMR,   X_RLO,  16'h0000},
    '{OP_BRD,  B_RSLT1,      2'b11, 16'h0000, 1'b0, K_MMR,   X_RHI,  16'h0000},
    '{OP_INP,  5'h00,        2'b11, 16'h0000, 1'b1, K_NONE,  X_TAB,  16'h0000},
    '{OP_BRD,  B_IN2,        2'b11, 16'h0000, 1'b0, K_MMR,   X_IN2,  16'h0000},
    '{OP_BRD,  B_IN3,        2'b11, 16'h0000, 1'b0, K_MMR,   X_IN3,  16'h0000},
    '{OP_BRD,  5'h1f,        2'b11, 16'h0000, 1'b0, K_MMR,   X_TAB,  16'hffff},
    '{OP_BRD,  5'h0d,        2'b11, 16'h0000, 1'b0, K_MMR,   X_TAB,  16'hffff}
};

`endif

/* cps_mmr_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench of the register block. Each table row takes one
// clk cycle, the configuration row one cycle per chain byte. Inputs change
// on the falling edge and outputs are checked on the next falling edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cps_mmr_tb import cps_mmr_pkg::*; #(
    parameter int unsigned seed = 32'h0a011771
);

    logic       clk, reg_rst, ppu1_cs, ppu2_cs, cfg_we, obj_dma_clr;
    waddr_t     addr;
    dsn_t       dsn;
    word_t      cpu_dout, mmr_dout;
    byte_t      cfg_data, joystick3, joystick4;
    logic [3:0] start_button, coin_input;
    logic       obj_dma_ok, pal_copy;
    word_t      hpos1, hpos2, hpos3, vpos1, vpos2, vpos3;
    word_t      hstar1, hstar2, vstar1, vstar2;
    word_t      vram1_base, vram2_base, vram3_base, vram_obj_base, vram_row_base;
    word_t      row_offset, pal_base, ppu_ctrl;
    word_t      layer_ctrl, prio0, prio1, prio2, prio3;
    logic [5:0] pal_page_en;
    byte_t      layer_mask0, layer_mask1, layer_mask2, layer_mask3, layer_mask4;
    game_t      game;
    word_t      bank_offset, bank_mask;

    `include "cps_mmr_tb_table.svh"

    localparam int RST_CYCLES  = 5;
    localparam int CYCLE_LIMIT = ROWS * 4 + RST_CYCLES + CFG_BYTES + 20;

    word_t a_model [18];
    word_t last_rand, mult_a, mult_b;
    int    cycles = 0;

    cps_mmr_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1);
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // DUT output behind a CPS-A word address
    function automatic word_t a_reg(input waddr_t a);
        case (a)
            A_OBJ_BASE:   return vram_obj_base;
            A_SCR1_BASE:  return vram1_base;
            A_SCR2_BASE:  return vram2_base;
            A_SCR3_BASE:  return vram3_base;
            A_ROW_BASE:   return vram_row_base;
            A_PAL_BASE:   return pal_base;
            A_HPOS1:      return hpos1;
            A_VPOS1:      return vpos1;
            A_HPOS2:      return hpos2;
            A_VPOS2:      return vpos2;
            A_HPOS3:      return hpos3;
            A_VPOS3:      return vpos3;
            A_HSTAR1:     return hstar1;
            A_VSTAR1:     return vstar1;
            A_HSTAR2:     return hstar2;
            A_VSTAR2:     return vstar2;
            A_ROW_OFFSET: return row_offset;
            default:      return ppu_ctrl;
        endcase
    endfunction

    // name of the DUT output behind a CPS-A word address
    function automatic string a_name(input waddr_t a);
        case (a)
            A_OBJ_BASE:   return "vram_obj_base";
            A_SCR1_BASE:  return "vram1_base";
            A_SCR2_BASE:  return "vram2_base";
            A_SCR3_BASE:  return "vram3_base";
            A_ROW_BASE:   return "vram_row_base";
            A_PAL_BASE:   return "pal_base";
            A_HPOS1:      return "hpos1";
            A_VPOS1:      return "vpos1";
            A_HPOS2:      return "hpos2";
            A_VPOS2:      return "vpos2";
            A_HPOS3:      return "hpos3";
            A_VPOS3:      return "vpos3";
            A_HSTAR1:     return "hstar1";
            A_VSTAR1:     return "vstar1";
            A_HSTAR2:     return "hstar2";
            A_VSTAR2:     return "vstar2";
            A_ROW_OFFSET: return "row_offset";
            default:      return "ppu_ctrl";
        endcase
    endfunction

    function automatic word_t expected_of(input row_t r);
        logic [31:0] product;
        byte_t       port;
        product = {16'd0, mult_a} * {16'd0, mult_b};
        case (r.src)
            X_RAND: return last_rand;
            X_RLO:  return product[15:0];
            X_RHI:  return product[31:16];
            X_IN2: begin
                port = {start_button[2], coin_input[2], joystick3[5:0]};
                return {port, port};
            end
            X_IN3: begin
                port = {start_button[3], coin_input[3], joystick4[5:0]};
                return {port, port};
            end
            default: return r.exp;
        endcase
    endfunction

    task automatic check_row(input row_t r);
        case (r.chk)
            K_CFG: begin
                check_byte("layer_mask0", layer_mask0, CFG_LIST[14]);
                check_byte("layer_mask1", layer_mask1, CFG_LIST[15]);
                check_byte("layer_mask2", layer_mask2, CFG_LIST[16]);
                check_byte("layer_mask3", layer_mask3, CFG_LIST[17]);
                check_byte("layer_mask4", layer_mask4, CFG_LIST[17]);
                check_byte("game", {2'b00, game}, {2'b00, CFG_LIST[18][5:0]});
                check_word("bank_offset", bank_offset, {CFG_LIST[20], CFG_LIST[19]});
                check_word("bank_mask", bank_mask, {CFG_LIST[22], CFG_LIST[21]});
            end
            K_MMR:   check_word("mmr_dout", mmr_dout, expected_of(r));
            K_LAYER: check_word("layer_ctrl", layer_ctrl, expected_of(r));
            K_PRIO0: check_word("prio0", prio0, r.exp);
            K_PRIO1: check_word("prio1", prio1, r.exp);
            K_PRIO2: check_word("prio2", prio2, r.exp);
            K_PRIO3: check_word("prio3", prio3, r.exp);
            K_PAL:   check_byte("pal_page_en", {2'b00, pal_page_en}, r.exp[7:0]);
            K_DMA:   check_flag("obj_dma_ok", obj_dma_ok, r.exp[0]);
            K_COPY:  check_flag("pal_copy", pal_copy, r.exp[0]);
            default: ;
        endcase
    endtask

    task automatic apply_row(input row_t r);
        word_t d;
        d = r.rnd ? word_t'($urandom) : r.data;
        if (r.op == OP_CFG) begin
            for (int i = CFG_BYTES - 1; i >= 0; i--) begin
                cfg_we   = 1'b1;
                cfg_data = CFG_LIST[i];
                @(posedge clk);
                @(negedge clk);
            end
            cfg_we = 1'b0;
        end else begin
            addr        = r.addr;
            dsn         = r.dsn;
            cpu_dout    = d;
            ppu1_cs     = (r.op == OP_AWR);
            ppu2_cs     = (r.op == OP_BWR) || (r.op == OP_BRD);
            obj_dma_clr = (r.op == OP_CLR);
            if (r.op == OP_INP) begin
                start_button = 4'($urandom);
                coin_input   = 4'($urandom);
                joystick3    = 8'($urandom);
                joystick4    = 8'($urandom);
            end
            @(posedge clk);
            @(negedge clk);
            ppu1_cs     = 1'b0;
            ppu2_cs     = 1'b0;
            obj_dma_clr = 1'b0;
        end
        // byte lanes with a low strobe take the new data, all others hold
        if (r.op == OP_AWR) begin
            if (!r.dsn[1]) a_model[r.addr][15:8] = d[15:8];
            if (!r.dsn[0]) a_model[r.addr][7:0] = d[7:0];
            for (int i = 0; i < 18; i++) begin
                check_word(a_name(waddr_t'(i)), a_reg(waddr_t'(i)), a_model[i]);
            end
        end
        if (r.op == OP_BWR && r.dsn == 2'b00) begin
            if (r.rnd) last_rand = d;
            if (r.addr == B_MULT1) mult_a = d;
            if (r.addr == B_MULT2) mult_b = d;
        end
        check_row(r);
    endtask

    initial begin
        void'($urandom(seed));
        reg_rst      = 1'b1;
        ppu1_cs      = 1'b0;
        ppu2_cs      = 1'b0;
        cfg_we       = 1'b0;
        obj_dma_clr  = 1'b0;
        addr         = '0;
        dsn          = 2'b11;
        cpu_dout     = '0;
        cfg_data     = '0;
        start_button = '0;
        coin_input   = '0;
        joystick3    = '0;
        joystick4    = '0;
        last_rand    = '0;
        mult_a       = '0;
        mult_b       = '0;
        for (int i = 0; i < 18; i++) begin
            a_model[i] = '0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        reg_rst = 1'b0;

        check_word("mmr_dout", mmr_dout, RD_IDLE);
        check_word("layer_ctrl", layer_ctrl, LAYER_CTRL_RST);
        check_byte("pal_page_en", {2'b00, pal_page_en}, {2'b00, PAL_PAGE_RST});
        check_flag("pal_copy", pal_copy, 1'b0);
        check_flag("obj_dma_ok", obj_dma_ok, 1'b0);
        check_word("prio0", prio0, 16'h0000);
        check_word("prio1", prio1, 16'h0000);
        check_word("prio2", prio2, 16'h0000);
        check_word("prio3", prio3, 16'h0000);
        for (int i = 0; i < 18; i++) begin
            check_word(a_name(waddr_t'(i)), a_reg(waddr_t'(i)), 16'h0000);
        end

        for (int n = 0; n < ROWS; n++) begin
            apply_row(table_rows[n]);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* cps_mmr_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPS-A/CPS-B register block: configuration chain plus both register files.
// Single-cycle chip-select bus with no wait states. The configuration
// chain must be fully loaded before any CPS-B access.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cps_mmr_top import cps_mmr_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,

    // CPU bus
    input  logic       ppu1_cs,
    input  logic       ppu2_cs,
    input  waddr_t     addr,
    input  dsn_t       dsn,
    input  word_t      cpu_dout,
    output word_t      mmr_dout,

    // configuration download
    input  logic       cfg_we,
    input  byte_t      cfg_data,

    input  logic       obj_dma_clr,
    output logic       obj_dma_ok,
    output logic       pal_copy,

    input  logic [3:0] start_button,
    input  logic [3:0] coin_input,
    input  byte_t      joystick3,
    input  byte_t      joystick4,

    // CPS-A outputs
    output word_t      hpos1, hpos2, hpos3,
    output word_t      vpos1, vpos2, vpos3,
    output word_t      hstar1, hstar2,
    output word_t      vstar1, vstar2,
    output word_t      vram1_base, vram2_base, vram3_base,
    output word_t      vram_obj_base, vram_row_base,
    output word_t      row_offset, pal_base, ppu_ctrl,

    // CPS-B outputs
    output word_t      layer_ctrl,
    output word_t      prio0, prio1, prio2, prio3,
    output logic [5:0] pal_page_en,
    output byte_t      layer_mask0, layer_mask1, layer_mask2,
    output byte_t      layer_mask3, layer_mask4,

    // ROM bank mapper
    output game_t      game,
    output word_t      bank_offset,
    output word_t      bank_mask
);

    // configured CPS-B addresses
    waddr_t addr_id, addr_mult1, addr_mult2, addr_rslt0, addr_rslt1;
    waddr_t addr_layer, addr_prio0, addr_prio1, addr_prio2, addr_prio3;
    waddr_t addr_pal_page, addr_in2, addr_in3;
    byte_t  cpsb_id;

    // chain feeds the CPS-B address decode
    cps_cfg_chain u_cfg_chain (.*);

    cps_a_regs u_a_regs (.*);

    cps_b_regs u_b_regs (.*);

endmodule

/* cps_b_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPS-B register file at addresses given by the configuration chain.
// Writes need both byte strobes low. mmr_dout is loaded on every clk edge
// with ppu2_cs high and holds in between. Multiplier operands and results
// have no reset; a result is valid two cycles after the last operand write.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cps_b_regs import cps_mmr_pkg::*; (
    input  logic       clk,
    input  logic       reg_rst,
    input  logic       ppu2_cs,
    input  waddr_t     addr,
    input  dsn_t       dsn,
    input  word_t      cpu_dout,

    input  waddr_t     addr_id,
    input  waddr_t     addr_mult1,
    input  waddr_t     addr_mult2,
    input  waddr_t     addr_rslt0,
    input  waddr_t     addr_rslt1,
    input  waddr_t     addr_layer,
    input  waddr_t     addr_prio0,
    input  waddr_t     addr_prio1,
    input  waddr_t     addr_prio2,
    input  waddr_t     addr_prio3,
    input  waddr_t     addr_pal_page,
    input  waddr_t     addr_in2,
    input  waddr_t     addr_in3,
    input  byte_t      cpsb_id,

    input  logic [3:0] start_button,
    input  logic [3:0] coin_input,
    input  byte_t      joystick3,
    input  byte_t      joystick4,

    output word_t      mmr_dout,
    output word_t      layer_ctrl,
    output word_t      prio0,
    output word_t      prio1,
    output word_t      prio2,
    output word_t      prio3,
    output logic [5:0] pal_page_en
);

    logic  sel_id, sel_mult1, sel_mult2, sel_rslt0, sel_rslt1, sel_layer;
    logic  sel_prio0, sel_prio1, sel_prio2, sel_prio3, sel_pal_page;
    logic  sel_in2, sel_in3;
    logic  b_wr;
    word_t mult1, mult2;
    word_t rslt0, rslt1;
    byte_t in2, in3;
    word_t rd_data;

    // ID, multiplier and priority slots are off at ADDR_OFF
    assign sel_id       = (addr == addr_id)    && (addr_id    != ADDR_OFF);
    assign sel_mult1    = (addr == addr_mult1) && (addr_mult1 != ADDR_OFF);
    assign sel_mult2    = (addr == addr_mult2) && (addr_mult2 != ADDR_OFF);
    assign sel_rslt0    = (addr == addr_rslt0) && (addr_rslt0 != ADDR_OFF);
    assign sel_rslt1    = (addr == addr_rslt1) && (addr_rslt1 != ADDR_OFF);
    assign sel_layer    = (addr == addr_layer);
    assign sel_prio0    = (addr == addr_prio0) && (addr_prio0 != ADDR_OFF);
    assign sel_prio1    = (addr == addr_prio1) && (addr_prio1 != ADDR_OFF);
    assign sel_prio2    = (addr == addr_prio2) && (addr_prio2 != ADDR_OFF);
    assign sel_prio3    = (addr == addr_prio3) && (addr_prio3 != ADDR_OFF);
    assign sel_pal_page = (addr == addr_pal_page);
    // extra input ports are absent when configured at zero
    assign sel_in2      = (addr == addr_in2) && (addr_in2 != '0);
    assign sel_in3      = (addr == addr_in3) && (addr_in3 != '0);

    assign b_wr = ppu2_cs && (dsn == 2'b00);

    // players 3 and 4 packed as start, coin, joystick
    assign in2 = {start_button[2], coin_input[2], joystick3[5:0]};
    assign in3 = {start_button[3], coin_input[3], joystick4[5:0]};

    always_ff @(posedge clk) begin
        if (b_wr && sel_mult1) mult1 <= cpu_dout;
        if (b_wr && sel_mult2) mult2 <= cpu_dout;
        {rslt1, rslt0} <= 32'(mult1) * 32'(mult2);
    end

    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            layer_ctrl  <= LAYER_CTRL_RST;
            prio0       <= '0;
            prio1       <= '0;
            prio2       <= '0;
            prio3       <= '0;
            pal_page_en <= PAL_PAGE_RST;
        end else if (b_wr) begin
            if (sel_layer)    layer_ctrl  <= cpu_dout;
            if (sel_prio0)    prio0       <= cpu_dout;
            if (sel_prio1)    prio1       <= cpu_dout;
            if (sel_prio2)    prio2       <= cpu_dout;
            if (sel_prio3)    prio3       <= cpu_dout;
            if (sel_pal_page) pal_page_en <= cpu_dout[5:0];
        end
    end

    // first group wins on overlapping addresses
    always_comb begin
        if (&addr)             rd_data = RD_IDLE;
        else if (sel_id)       rd_data = {4'd0, cpsb_id[7:4], 4'd0, cpsb_id[3:0]};
        else if (sel_mult1)    rd_data = mult1;
        else if (sel_mult2)    rd_data = mult2;
        else if (sel_rslt0)    rd_data = rslt0;
        else if (sel_rslt1)    rd_data = rslt1;
        else if (sel_layer)    rd_data = layer_ctrl;
        else if (sel_prio0)    rd_data = prio0;
        else if (sel_prio1)    rd_data = prio1;
        else if (sel_prio2)    rd_data = prio2;
        else if (sel_prio3)    rd_data = prio3;
        else if (sel_pal_page) rd_data = {10'd0, pal_page_en};
        else if (sel_in2)      rd_data = {in2, in2};
        else if (sel_in3)      rd_data = {in3, in3};
        else                   rd_data = RD_IDLE;
    end

    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            mmr_dout <= RD_IDLE;
        end else if (ppu2_cs) begin
            mmr_dout <= rd_data;
        end
    end

endmodule

/* cps_a_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPS-A register file at fixed word addresses, write only.
// Every clk edge with ppu1_cs high is one write; a byte whose strobe is
// high keeps its old value. pal_copy is a one-cycle pulse issued after
// ppu1_cs has dropped following a palette base write.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cps_a_regs import cps_mmr_pkg::*; (
    input  logic   clk,
    input  logic   reg_rst,
    input  logic   ppu1_cs,
    input  logic   obj_dma_clr,
    input  waddr_t addr,
    input  dsn_t   dsn,
    input  word_t  cpu_dout,

    output word_t  hpos1,
    output word_t  hpos2,
    output word_t  hpos3,
    output word_t  vpos1,
    output word_t  vpos2,
    output word_t  vpos3,
    output word_t  hstar1,
    output word_t  hstar2,
    output word_t  vstar1,
    output word_t  vstar2,
    output word_t  vram1_base,
    output word_t  vram2_base,
    output word_t  vram3_base,
    output word_t  vram_obj_base,
    output word_t  vram_row_base,
    output word_t  row_offset,
    output word_t  pal_base,
    output word_t  ppu_ctrl,
    output logic   obj_dma_ok,
    output logic   pal_copy
);

    copy_state_e copy_state;
    logic        obj_wr;
    logic        pal_wr;

    // per-byte merge of old and new data, strobes active low
    function automatic word_t lane_merge(word_t old_w, word_t new_w, dsn_t strb);
        word_t merged;
        merged[15:8] = strb[1] ? old_w[15:8] : new_w[15:8];
        merged[7:0]  = strb[0] ? old_w[7:0]  : new_w[7:0];
        return merged;
    endfunction

    assign obj_wr = ppu1_cs && (addr == A_OBJ_BASE);
    assign pal_wr = ppu1_cs && (addr == A_PAL_BASE);

    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            vram_obj_base <= '0;
            vram1_base    <= '0;
            vram2_base    <= '0;
            vram3_base    <= '0;
            vram_row_base <= '0;
            pal_base      <= '0;
            hpos1         <= '0;
            vpos1         <= '0;
            hpos2         <= '0;
            vpos2         <= '0;
            hpos3         <= '0;
            vpos3         <= '0;
            hstar1        <= '0;
            vstar1        <= '0;
            hstar2        <= '0;
            vstar2        <= '0;
            row_offset    <= '0;
            ppu_ctrl      <= '0;
        end else if (ppu1_cs) begin
            case (addr)
                A_OBJ_BASE:   vram_obj_base <= lane_merge(vram_obj_base, cpu_dout, dsn);
                A_SCR1_BASE:  vram1_base    <= lane_merge(vram1_base, cpu_dout, dsn);
                A_SCR2_BASE:  vram2_base    <= lane_merge(vram2_base, cpu_dout, dsn);
                A_SCR3_BASE:  vram3_base    <= lane_merge(vram3_base, cpu_dout, dsn);
                A_ROW_BASE:   vram_row_base <= lane_merge(vram_row_base, cpu_dout, dsn);
                A_PAL_BASE:   pal_base      <= lane_merge(pal_base, cpu_dout, dsn);
                A_HPOS1:      hpos1         <= lane_merge(hpos1, cpu_dout, dsn);
                A_VPOS1:      vpos1         <= lane_merge(vpos1, cpu_dout, dsn);
                A_HPOS2:      hpos2         <= lane_merge(hpos2, cpu_dout, dsn);
                A_VPOS2:      vpos2         <= lane_merge(vpos2, cpu_dout, dsn);
                A_HPOS3:      hpos3         <= lane_merge(hpos3, cpu_dout, dsn);
                A_VPOS3:      vpos3         <= lane_merge(vpos3, cpu_dout, dsn);
                A_HSTAR1:     hstar1        <= lane_merge(hstar1, cpu_dout, dsn);
                A_VSTAR1:     vstar1        <= lane_merge(vstar1, cpu_dout, dsn);
                A_HSTAR2:     hstar2        <= lane_merge(hstar2, cpu_dout, dsn);
                A_VSTAR2:     vstar2        <= lane_merge(vstar2, cpu_dout, dsn);
                A_ROW_OFFSET: row_offset    <= lane_merge(row_offset, cpu_dout, dsn);
                A_PPU_CTRL:   ppu_ctrl      <= lane_merge(ppu_ctrl, cpu_dout, dsn);
                default: ;
            endcase
        end
    end

    // a new object base write wins over the clear
    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            obj_dma_ok <= 1'b0;
        end else if (obj_wr) begin
            obj_dma_ok <= 1'b1;
        end else if (obj_dma_clr) begin
            obj_dma_ok <= 1'b0;
        end
    end

    // wait for ppu1_cs low so the palette engine sees the final pal_base
    always_ff @(posedge clk, posedge reg_rst) begin
        if (reg_rst) begin
            copy_state <= COPY_IDLE;
        end else if (pal_wr) begin
            copy_state <= COPY_ARMED;
        end else begin
            case (copy_state)
                COPY_ARMED: if (!ppu1_cs) copy_state <= COPY_FIRE;
                COPY_FIRE:  copy_state <= COPY_IDLE;
                default:    copy_state <= COPY_IDLE;
            endcase
        end
    end

    assign pal_copy = (copy_state == COPY_FIRE);

endmodule

/* cps_cfg_chain.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-serial configuration chain for the game-specific CPS-B map.
// The chain has no reset: all CFG_BYTES bytes must be shifted in before
// the CPS-B registers or the mapper fields are used. The first byte sent
// ends up in the highest position.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cps_cfg_chain import cps_mmr_pkg::*; (
    input  logic   clk,
    input  logic   cfg_we,
    input  byte_t  cfg_data,

    output waddr_t addr_id,
    output waddr_t addr_mult1,
    output waddr_t addr_mult2,
    output waddr_t addr_rslt0,
    output waddr_t addr_rslt1,
    output waddr_t addr_layer,
    output waddr_t addr_prio0,
    output waddr_t addr_prio1,
    output waddr_t addr_prio2,
    output waddr_t addr_prio3,
    output waddr_t addr_pal_page,
    output waddr_t addr_in2,
    output waddr_t addr_in3,
    output byte_t  cpsb_id,

    output byte_t  layer_mask0,
    output byte_t  layer_mask1,
    output byte_t  layer_mask2,
    output byte_t  layer_mask3,
    output byte_t  layer_mask4,
    output game_t  game,
    output word_t  bank_offset,
    output word_t  bank_mask
);

    byte_t [CFG_BYTES-1:0] chain;

    // new byte enters at position 0
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            chain <= {chain[CFG_BYTES-2:0], cfg_data};
        end
    end

    // configuration bytes hold byte addresses, so drop bit 0
    assign addr_id       = chain[0][5:1];
    assign cpsb_id       = chain[1];
    assign addr_mult1    = chain[2][5:1];
    assign addr_mult2    = chain[3][5:1];
    assign addr_rslt0    = chain[4][5:1];
    assign addr_rslt1    = chain[5][5:1];
    assign addr_layer    = chain[6][5:1];
    assign addr_prio0    = chain[7][5:1];
    assign addr_prio1    = chain[8][5:1];
    assign addr_prio2    = chain[9][5:1];
    assign addr_prio3    = chain[10][5:1];
    assign addr_in2      = chain[11][5:1];
    assign addr_in3      = chain[12][5:1];
    assign addr_pal_page = chain[13][5:1];

    assign layer_mask0   = chain[14];
    assign layer_mask1   = chain[15];
    assign layer_mask2   = chain[16];
    assign layer_mask3   = chain[17];
    // layer 4 has no byte of its own and shares the layer 3 mask
    assign layer_mask4   = chain[17];

    // ROM bank mapper in the last five bytes with the low byte first
    assign game          = chain[18][5:0];
    assign bank_offset   = {chain[20], chain[19]};
    assign bank_mask     = {chain[22], chain[21]};

endmodule

/* cps_mmr_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, CPS-A register map and reset values of the CPS-A/CPS-B
// register block. CPU addresses are word addresses (byte address bits 5:1)
// and the byte strobes are active low, bit 1 being the upper byte.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cps_mmr_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  waddr_t;
    typedef logic [1:0]  dsn_t;
    typedef logic [5:0]  game_t;

    // configuration chain length, loaded during ROM download
    localparam int CFG_BYTES = 23;

    // a configurable register at this address is switched off
    localparam waddr_t ADDR_OFF = 5'h1f;

    // CPS-A fixed word addresses
    localparam waddr_t A_OBJ_BASE   = 5'h00;
    localparam waddr_t A_SCR1_BASE  = 5'h01;
    localparam waddr_t A_SCR2_BASE  = 5'h02;
    localparam waddr_t A_SCR3_BASE  = 5'h03;
    localparam waddr_t A_ROW_BASE   = 5'h04;
    localparam waddr_t A_PAL_BASE   = 5'h05;
    localparam waddr_t A_HPOS1      = 5'h06;
    localparam waddr_t A_VPOS1      = 5'h07;
    localparam waddr_t A_HPOS2      = 5'h08;
    localparam waddr_t A_VPOS2      = 5'h09;
    localparam waddr_t A_HPOS3      = 5'h0a;
    localparam waddr_t A_VPOS3      = 5'h0b;
    localparam waddr_t A_HSTAR1     = 5'h0c;
    localparam waddr_t A_VSTAR1     = 5'h0d;
    localparam waddr_t A_HSTAR2     = 5'h0e;
    localparam waddr_t A_VSTAR2     = 5'h0f;
    localparam waddr_t A_ROW_OFFSET = 5'h10;
    localparam waddr_t A_PPU_CTRL   = 5'h11;

    // default layer order 3, 2, 1, 0 in bits 12:5
    localparam word_t LAYER_CTRL_RST = {3'b000, 2'b11, 2'b10, 2'b01, 2'b00, 5'd0};

    // all six palette pages copied
    localparam logic [5:0] PAL_PAGE_RST = 6'h3f;

    localparam word_t RD_IDLE = 16'hffff;

    // palette copy sequencer
    typedef enum logic [1:0] {
        COPY_IDLE,
        COPY_ARMED,
        COPY_FIRE
    } copy_state_e;

endpackage
